//--- verilog.f
+incdir+source
source/bubble_pkg.sv
source/led_blinker.sv
source/startup_ctrl.sv
source/tc77_reader.sv
source/temp_monitor.sv
source/bubble_drive_top.sv
test/tc77_model.sv
test/tb_bubble_drive.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator; the log decides pass or fail.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_bubble_drive -f verilog.f \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vtb_bubble_drive > sim.log 2>&1
cat sim.log

grep -qx "tests failed" sim.log && { echo "simulation FAILED"; exit 1; } || echo "simulation ok"

//--- test/tb_bubble_drive.sv
`timescale 1ns/1ps
`include "bubble_params.svh"

module tb_bubble_drive;

    // about four times the longest path through the whole sequence
    localparam int CYCLE_LIMIT = 40000;
    localparam int BLINK_LIMIT = 2 * `BLINK_HALF_PERIOD + 2;
    localparam int READ_WAIT   = `TEMP_POLL_CYCLES + 70;

    logic                   MCLK        = 1'b0;
    logic                   MRST        = 1'b1;
    logic                   usb_power   = 1'b0;
    logic                   board_fault = 1'b0;
    logic                   fan_sw      = 1'b0;
    logic                   force_start = 1'b0;
    bubble_pkg::delay_sel_t delay_sel   = '0;
    logic                   temp_sio;
    logic                   emu_en;
    logic                   usb_en;
    logic                   temp_cs_n;
    logic                   temp_sck;
    logic                   temp_low;
    logic                   fan_en;
    logic                   led_pwrok_n;
    logic                   led_standby_n;
    logic                   led_delaying_n;

    bubble_pkg::temp_t     sensor_temp = 13'sd400;
    bubble_pkg::run_mode_t ref_mode    = bubble_pkg::mode_reset;
    logic [31:0]           rng_state   = 32'h39950eb0;
    int                    cycle_cnt   = 0;

    always #10 MCLK = ~MCLK;

    bubble_drive_top u_bubble_drive_top
    (
        .MCLK           (MCLK),
        .MRST           (MRST),
        .usb_power      (usb_power),
        .board_fault    (board_fault),
        .fan_sw         (fan_sw),
        .force_start    (force_start),
        .delay_sel      (delay_sel),
        .temp_sio       (temp_sio),
        .emu_en         (emu_en),
        .usb_en         (usb_en),
        .temp_cs_n      (temp_cs_n),
        .temp_sck       (temp_sck),
        .temp_low       (temp_low),
        .fan_en         (fan_en),
        .led_pwrok_n    (led_pwrok_n),
        .led_standby_n  (led_standby_n),
        .led_delaying_n (led_delaying_n)
    );

    tc77_model u_tc77_model
    (
        .cs_n (temp_cs_n),
        .sck  (temp_sck),
        .temp (sensor_temp),
        .sio  (temp_sio)
    );

    //////////////////////////////////////////////////////////////////////
    // failure reporting

    task automatic stop_failed(input string line);
        $display("%s", line);
        $display("tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic fail_reason(input string why);
        stop_failed($sformatf("[ERROR] %0t: %s", $time, why));
    endtask

    task automatic check_value(input string name, input logic got, input logic exp);
        assert (got === exp)
        else stop_failed($sformatf("[ERROR] %0t: %s = %b, expected %b", $time, name, got, exp));
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference rules

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // mode chosen from (usb_power, board_fault) on a fresh selection
    function automatic bubble_pkg::run_mode_t pick_mode(input logic up, input logic bf);
        case ({up, bf})
            2'b00: return bubble_pkg::mode_emulator;
            2'b01: return bubble_pkg::mode_err_board;
            2'b10: return bubble_pkg::mode_err_supply;
            default: return bubble_pkg::mode_usb_standby;
        endcase
    endfunction

    // emulator latches, board error waits for the fault to drop,
    // the rest re-select on any change
    function automatic bubble_pkg::run_mode_t next_mode(input bubble_pkg::run_mode_t cur,
                                                        input logic up, input logic bf);
        if (cur == bubble_pkg::mode_emulator)
            return cur;
        if (cur == bubble_pkg::mode_err_board && bf)
            return cur;
        return pick_mode(up, bf);
    endfunction

    function automatic int warmup_cycles(input bubble_pkg::delay_sel_t sel);
        case (sel)
            2'd0: return `WARMUP_DELAY_0;
            2'd1: return `WARMUP_DELAY_1;
            2'd2: return `WARMUP_DELAY_2;
            default: return `WARMUP_DELAY_3;
        endcase
    endfunction

    function automatic logic led_level(input int sel);
        return (sel == 0) ? led_pwrok_n : led_standby_n;
    endfunction

    // in emulator mode the standby LED shows only the warm-up delay
    function automatic logic delaying_now();
        return !led_standby_n;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // stimulus tasks

    task automatic check_mode_outputs();
        check_value("emu_en", emu_en, ref_mode == bubble_pkg::mode_emulator);
        check_value("usb_en", usb_en, ref_mode == bubble_pkg::mode_usb_standby);
    endtask

    task automatic reset_into(input logic up, input logic bf);
        @(posedge MCLK);
        MRST        <= 1'b1;
        usb_power   <= up;
        board_fault <= bf;
        repeat (9) @(posedge MCLK);
        @(negedge MCLK);
        check_value("emu_en", emu_en, 1'b0);
        check_value("usb_en", usb_en, 1'b0);
        check_value("fan_en", fan_en, 1'b0);
        check_value("temp_low", temp_low, 1'b0);
        check_value("temp_cs_n", temp_cs_n, 1'b1);
        check_value("temp_sck", temp_sck, 1'b0);
        check_value("led_pwrok_n", led_pwrok_n, 1'b1);
        check_value("led_standby_n", led_standby_n, 1'b1);
        check_value("led_delaying_n", led_delaying_n, 1'b1);
        @(posedge MCLK);
        MRST <= 1'b0;
        ref_mode = pick_mode(up, bf);
        repeat (4) @(posedge MCLK);
        @(negedge MCLK);
        check_mode_outputs();
    endtask

    task automatic change_inputs(input logic up, input logic bf);
        bubble_pkg::run_mode_t prev;
        int                    i;
        prev = ref_mode;
        @(posedge MCLK);
        usb_power   <= up;
        board_fault <= bf;
        ref_mode = next_mode(ref_mode, up, bf);
        // a held mode keeps its enables through the whole change
        for (i = 0; i < 5; i++)
        begin
            @(negedge MCLK);
            if (ref_mode == prev || i == 4)
                check_mode_outputs();
        end
    endtask

    task automatic expect_toggle(input int sel, input string name);
        logic start;
        logic seen;
        int   i;
        @(negedge MCLK);
        start = led_level(sel);
        seen  = 1'b0;
        for (i = 0; i < BLINK_LIMIT && !seen; i++)
        begin
            @(negedge MCLK);
            seen = (led_level(sel) != start);
        end
        assert (seen)
        else fail_reason($sformatf("%s did not toggle within %0d cycles", name, BLINK_LIMIT));
    endtask

    task automatic expect_steady(input int sel, input string name, input logic level,
                                 input int cycles);
        repeat (cycles)
        begin
            @(negedge MCLK);
            check_value(name, led_level(sel), level);
        end
    endtask

    task automatic wait_temp_low(input logic level);
        int waited;
        waited = 0;
        @(negedge MCLK);
        while (temp_low != level && waited < READ_WAIT)
        begin
            @(negedge MCLK);
            waited++;
        end
        check_value("temp_low", temp_low, level);
    endtask

    // counts negedges until the delay flag reaches the level
    task automatic wait_delaying(input logic level, input int limit, output int waited);
        waited = 0;
        @(negedge MCLK);
        while (delaying_now() != level && waited < limit)
        begin
            @(negedge MCLK);
            waited++;
        end
        assert (delaying_now() == level)
        else fail_reason($sformatf("delaying did not reach %b within %0d cycles", level, limit));
    endtask

    task automatic warmup_round(input int round);
        bubble_pkg::delay_sel_t sel;
        int                     dly;
        int                     waited;
        int                     spread;
        rng_state = xorshift32(rng_state);
        sel       = rng_state[1:0];
        dly       = warmup_cycles(sel);
        spread    = int'(rng_state[15:8]);
        @(posedge MCLK);
        sensor_temp <= bubble_pkg::temp_t'(`TEMP_LOW_LIMIT - 1 - spread);
        delay_sel   <= sel;
        fan_sw      <= rng_state[20];
        wait_temp_low(1'b1);
        // a delay left over from earlier readings is cut short first
        @(posedge MCLK);
        force_start <= 1'b1;
        @(posedge MCLK);
        force_start <= 1'b0;
        wait_delaying(1'b0, 2, waited);
        @(posedge MCLK);
        sensor_temp <= bubble_pkg::temp_t'(`TEMP_LOW_LIMIT + spread);
        wait_delaying(1'b1, READ_WAIT, waited);
        if (round == 2)
        begin
            repeat (50) @(posedge MCLK);
            force_start <= 1'b1;
            @(posedge MCLK);
            force_start <= 1'b0;
            wait_delaying(1'b0, 2, waited);
        end
        else
        begin
            wait_delaying(1'b0, dly + `TEMP_POLL_CYCLES, waited);
            assert (waited + 1 >= dly && waited + 1 <= dly + `TEMP_POLL_CYCLES)
            else fail_reason($sformatf("delaying lasted %0d cycles, expected %0d to %0d",
                                       waited + 1, dly, dly + `TEMP_POLL_CYCLES));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // emulator mode rules checked every cycle

    fan_rule: assert property (@(posedge MCLK) disable iff (MRST)
        emu_en |-> (fan_en == (fan_sw && (temp_low || !led_standby_n))))
    else stop_failed($sformatf("[ERROR] %0t: fan_en = %b, expected %b", $time,
                               $sampled(fan_en),
                               $sampled(fan_sw) & ($sampled(temp_low) | ~$sampled(led_standby_n))));

    delay_led_rule: assert property (@(posedge MCLK) disable iff (MRST)
        emu_en |-> (led_delaying_n == led_standby_n))
    else stop_failed($sformatf("[ERROR] %0t: led_delaying_n = %b, expected %b", $time,
                               $sampled(led_delaying_n), $sampled(led_standby_n)));

    always @(posedge MCLK)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == CYCLE_LIMIT)
            fail_reason("cycle limit reached before the tests finished");
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence

    initial
    begin
        int n;
        int base;

        // mode selection after reset for all four input pairs
        reset_into(1'b0, 1'b0);
        reset_into(1'b0, 1'b1);
        reset_into(1'b1, 1'b0);
        reset_into(1'b1, 1'b1);

        // standby blinks the standby LED while pwrok stays lit
        expect_toggle(1, "led_standby_n");
        expect_toggle(1, "led_standby_n");
        expect_steady(0, "led_pwrok_n", 1'b0, BLINK_LIMIT);

        change_inputs(1'b1, 1'b0);
        expect_toggle(0, "led_pwrok_n");
        expect_toggle(0, "led_pwrok_n");
        change_inputs(1'b0, 1'b1);
        expect_toggle(0, "led_pwrok_n");
        expect_toggle(0, "led_pwrok_n");
        // board error holds while the fault is present
        change_inputs(1'b1, 1'b1);
        change_inputs(1'b0, 1'b0);
        expect_steady(0, "led_pwrok_n", 1'b0, 40);
        // emulator ignores input changes
        change_inputs(1'b1, 1'b1);
        change_inputs(1'b0, 1'b0);

        // random temperatures including negative ones
        for (n = 0; n < 8; n++)
        begin
            rng_state = xorshift32(rng_state);
            base      = int'(rng_state % 32'd1024);
            @(posedge MCLK);
            sensor_temp <= bubble_pkg::temp_t'(base - 200);
            fan_sw      <= rng_state[12];
            repeat (READ_WAIT) @(posedge MCLK);
            @(negedge MCLK);
            check_value("temp_low", temp_low, int'(sensor_temp) < `TEMP_LOW_LIMIT);
        end

        // warm-up delay with two full expiries and one forced start
        for (n = 0; n < 3; n++)
            warmup_round(n);

        $display("all tests passed");
        $finish;
    end

endmodule

//--- test/tc77_model.sv
`timescale 1ns/1ps

module tc77_model
(
    input  logic              cs_n,
    input  logic              sck,
    input  bubble_pkg::temp_t temp,
    output logic              sio
);

    logic [15:0] frame = '0;

    // frame is taken when cs_n falls, so a temperature change mid-read
    // only shows up in the next frame
    always @(negedge cs_n)
    begin
        // bit 2 flags a finished conversion, bits 1:0 read as zero
        frame = {temp, 3'b100};
    end

    // the sensor moves to the next bit on the falling clock edge
    always @(negedge sck)
    begin
        if (!cs_n)
            frame = {frame[14:0], 1'b0};
    end

    // MSB is on the line as soon as cs_n is low
    assign sio = !cs_n && frame[15];

endmodule

//--- source/bubble_drive_top.sv
`timescale 1ns/1ps

module bubble_drive_top
(
    input  logic                   MCLK,
    input  logic                   MRST,
    input  logic                   usb_power,
    input  logic                   board_fault,
    input  logic                   fan_sw,
    input  logic                   force_start,
    input  bubble_pkg::delay_sel_t delay_sel,
    input  logic                   temp_sio,
    output logic                   emu_en,
    output logic                   usb_en,
    output logic                   temp_cs_n,
    output logic                   temp_sck,
    output logic                   temp_low,
    output logic                   fan_en,
    output logic                   led_pwrok_n,
    output logic                   led_standby_n,
    output logic                   led_delaying_n
);

    logic temp_en;
    logic blink_en;
    logic blink;
    logic ctl_pwrok;
    logic ctl_standby;
    logic ctl_delaying;
    logic delaying;

    startup_ctrl u_startup_ctrl
    (
        .MCLK         (MCLK),
        .MRST         (MRST),
        .usb_power    (usb_power),
        .board_fault  (board_fault),
        .emu_en       (emu_en),
        .usb_en       (usb_en),
        .temp_en      (temp_en),
        .blink_en     (blink_en),
        .ctl_pwrok    (ctl_pwrok),
        .ctl_standby  (ctl_standby),
        .ctl_delaying (ctl_delaying)
    );

    led_blinker u_led_blinker
    (
        .MCLK     (MCLK),
        .MRST     (MRST),
        .blink_en (blink_en),
        .blink    (blink)
    );

    temp_monitor u_temp_monitor
    (
        .MCLK        (MCLK),
        .MRST        (MRST),
        .temp_en     (temp_en),
        .fan_sw      (fan_sw),
        .force_start (force_start),
        .delay_sel   (delay_sel),
        .temp_sio    (temp_sio),
        .temp_cs_n   (temp_cs_n),
        .temp_sck    (temp_sck),
        .temp_low    (temp_low),
        .delaying    (delaying),
        .fan_en      (fan_en)
    );

    //////////////////////////////////////////////////////////////////////
    // LED drive, active low

    // steady when ctl_pwrok is set, else lit in the low blink phase
    assign led_pwrok_n    = ~(ctl_pwrok | ~blink);
    assign led_standby_n  = ~((ctl_standby & ~blink) | delaying);
    assign led_delaying_n = ~(ctl_delaying & delaying);

endmodule

//--- source/temp_monitor.sv
`timescale 1ns/1ps
`include "bubble_params.svh"

module temp_monitor
(
    input  logic                   MCLK,
    input  logic                   MRST,
    input  logic                   temp_en,
    input  logic                   fan_sw,
    input  logic                   force_start,
    input  bubble_pkg::delay_sel_t delay_sel,
    input  logic                   temp_sio,
    output logic                   temp_cs_n,
    output logic                   temp_sck,
    output logic                   temp_low,
    output logic                   delaying,
    output logic                   fan_en
);

    localparam int POLL_W = $clog2(`TEMP_POLL_CYCLES);
    localparam int DLY_W  = $clog2(`WARMUP_DELAY_3 + 1);

    logic              rd_rst;
    logic              read_start;
    logic              read_done;
    bubble_pkg::temp_t read_temp;
    logic              reading_cold;
    logic              en_seen;
    logic              busy;
    logic [POLL_W-1:0] poll_cnt;
    logic [DLY_W-1:0]  dly_cnt;
    logic [DLY_W-1:0]  dly_load;

    // sensor reader sits idle while disabled
    assign rd_rst = MRST | ~temp_en;

    tc77_reader u_tc77_reader
    (
        .MCLK       (MCLK),
        .MRST       (rd_rst),
        .read_start (read_start),
        .temp_sio   (temp_sio),
        .temp_cs_n  (temp_cs_n),
        .temp_sck   (temp_sck),
        .read_done  (read_done),
        .read_temp  (read_temp)
    );

    //////////////////////////////////////////////////////////////////////
    // poll timer

    always_ff @(posedge MCLK)
    begin
        if (MRST || !temp_en)
        begin
            en_seen    <= 1'b0;
            busy       <= 1'b0;
            poll_cnt   <= '0;
            read_start <= 1'b0;
        end
        else
        begin
            read_start <= 1'b0;
            if (read_done)
                busy <= 1'b0;
            // first read right after enable, then once per poll period
            if (!en_seen || poll_cnt == POLL_W'(`TEMP_POLL_CYCLES - 1))
            begin
                en_seen  <= 1'b1;
                poll_cnt <= '0;
                if (!busy)
                begin
                    read_start <= 1'b1;
                    busy       <= 1'b1;
                end
            end
            else
            begin
                poll_cnt <= poll_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // cold detect and warm-up delay

    assign reading_cold = (read_temp < `TEMP_LOW_LIMIT);

    always_comb
    begin
        case (delay_sel)
            2'd0: dly_load = DLY_W'(`WARMUP_DELAY_0 - 1);
            2'd1: dly_load = DLY_W'(`WARMUP_DELAY_1 - 1);
            2'd2: dly_load = DLY_W'(`WARMUP_DELAY_2 - 1);
            default: dly_load = DLY_W'(`WARMUP_DELAY_3 - 1);
        endcase
    end

    always_ff @(posedge MCLK)
    begin
        if (MRST || !temp_en)
        begin
            temp_low <= 1'b0;
            delaying <= 1'b0;
            dly_cnt  <= '0;
        end
        else
        begin
            if (delaying)
            begin
                if (dly_cnt == '0)
                    delaying <= 1'b0;
                else
                    dly_cnt <= dly_cnt - 1'b1;
            end
            if (read_done)
            begin
                temp_low <= reading_cold;
                if (reading_cold && delaying)
                begin
                    // cooled off again, start the delay over
                    delaying <= 1'b1;
                    dly_cnt  <= dly_load;
                end
                else if (!reading_cold && temp_low)
                begin
                    delaying <= 1'b1;
                    dly_cnt  <= dly_load;
                end
            end
            // user skips the warm-up
            if (force_start)
                delaying <= 1'b0;
        end
    end

    // fan runs while cold or warming up
    assign fan_en = temp_en & fan_sw & (temp_low | delaying);

endmodule

//--- source/tc77_reader.sv
`timescale 1ns/1ps
`include "bubble_params.svh"

module tc77_reader
(
    input  logic              MCLK,
    input  logic              MRST,
    input  logic              read_start,
    input  logic              temp_sio,
    output logic              temp_cs_n,
    output logic              temp_sck,
    output logic              read_done,
    output bubble_pkg::temp_t read_temp
);

    localparam int FRAME_BITS = 16;
    localparam int DIV_W      = $clog2(`TEMP_SCK_DIV) + 1;
    localparam int BIT_W      = $clog2(FRAME_BITS);

    typedef enum logic [1:0]
    {
        rd_idle,
        rd_shift,
        rd_finish
    } rd_state_t;

    rd_state_t             state;
    logic [DIV_W-1:0]      div_cnt;
    logic [BIT_W-1:0]      bit_cnt;
    logic [FRAME_BITS-1:0] frame;
    logic                  half_end;

    // end of one sensor clock half-period
    assign half_end = (div_cnt == DIV_W'(`TEMP_SCK_DIV - 1));

    //////////////////////////////////////////////////////////////////////
    // frame control

    always_ff @(posedge MCLK)
    begin
        if (MRST)
        begin
            state     <= rd_idle;
            temp_cs_n <= 1'b1;
            temp_sck  <= 1'b0;
            div_cnt   <= '0;
            bit_cnt   <= '0;
            read_done <= 1'b0;
        end
        else
        begin
            read_done <= 1'b0;
            case (state)
                rd_idle:
                    if (read_start)
                    begin
                        state     <= rd_shift;
                        temp_cs_n <= 1'b0;
                        div_cnt   <= '0;
                        bit_cnt   <= '0;
                    end

                rd_shift:
                    if (half_end)
                    begin
                        div_cnt  <= '0;
                        temp_sck <= ~temp_sck;
                        // count bits on the falling edge
                        if (temp_sck)
                        begin
                            if (bit_cnt == BIT_W'(FRAME_BITS - 1))
                            begin
                                state     <= rd_finish;
                                temp_cs_n <= 1'b1;
                            end
                            else
                            begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end
                    end
                    else
                    begin
                        div_cnt <= div_cnt + 1'b1;
                    end

                rd_finish:
                begin
                    read_done <= 1'b1;
                    state     <= rd_idle;
                end

                default:
                    state <= rd_idle;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // data path, MSB first

    always_ff @(posedge MCLK)
    begin
        // sample as sck rises
        if (state == rd_shift && half_end && !temp_sck)
            frame <= {frame[FRAME_BITS-2:0], temp_sio};
        // low 3 bits are status, not temperature
        if (state == rd_finish)
            read_temp <= frame[FRAME_BITS-1:3];
    end

endmodule

//--- source/startup_ctrl.sv
`timescale 1ns/1ps

module startup_ctrl
(
    input  logic MCLK,
    input  logic MRST,
    input  logic usb_power,
    input  logic board_fault,
    output logic emu_en,
    output logic usb_en,
    output logic temp_en,
    output logic blink_en,
    output logic ctl_pwrok,
    output logic ctl_standby,
    output logic ctl_delaying
);

    bubble_pkg::run_mode_t state;
    bubble_pkg::run_mode_t state_next;

    //////////////////////////////////////////////////////////////////////
    // mode state machine

    always_comb
    begin
        state_next = state;
        case (state)
            bubble_pkg::mode_reset:
                state_next = bubble_pkg::mode_select;

            bubble_pkg::mode_select:
                case ({usb_power, board_fault})
                    2'b00: state_next = bubble_pkg::mode_emulator;
                    2'b01: state_next = bubble_pkg::mode_err_board;
                    2'b10: state_next = bubble_pkg::mode_err_supply;
                    default: state_next = bubble_pkg::mode_usb_standby;
                endcase

            // emulator holds until the next MRST
            bubble_pkg::mode_emulator:
                state_next = bubble_pkg::mode_emulator;

            bubble_pkg::mode_usb_standby:
                if ({usb_power, board_fault} != 2'b11)
                    state_next = bubble_pkg::mode_reset;

            // board fault clears -> try again
            bubble_pkg::mode_err_board:
                if (!board_fault)
                    state_next = bubble_pkg::mode_reset;

            bubble_pkg::mode_err_supply:
                if ({usb_power, board_fault} != 2'b10)
                    state_next = bubble_pkg::mode_reset;

            default:
                state_next = bubble_pkg::mode_reset;
        endcase
    end

    always_ff @(posedge MCLK)
    begin
        if (MRST)
            state <= bubble_pkg::mode_reset;
        else
            state <= state_next;
    end

    //////////////////////////////////////////////////////////////////////
    // registered output decode

    always_ff @(posedge MCLK)
    begin
        if (MRST || state == bubble_pkg::mode_reset)
        begin
            emu_en       <= 1'b0;
            usb_en       <= 1'b0;
            temp_en      <= 1'b0;
            blink_en     <= 1'b0;
            ctl_pwrok    <= 1'b0;
            ctl_standby  <= 1'b0;
            ctl_delaying <= 1'b0;
        end
        else
        begin
            case (state)
                bubble_pkg::mode_emulator:
                begin
                    emu_en       <= 1'b1;
                    usb_en       <= 1'b0;
                    temp_en      <= 1'b1;
                    blink_en     <= 1'b0;
                    ctl_pwrok    <= 1'b1;
                    ctl_standby  <= 1'b0;
                    ctl_delaying <= 1'b1;
                end

                bubble_pkg::mode_usb_standby:
                begin
                    emu_en       <= 1'b0;
                    usb_en       <= 1'b1;
                    temp_en      <= 1'b0;
                    blink_en     <= 1'b1;
                    ctl_pwrok    <= 1'b1;
                    ctl_standby  <= 1'b1;
                    ctl_delaying <= 1'b0;
                end

                // pwrok LED is lit by the blinker alone here
                bubble_pkg::mode_err_board,
                bubble_pkg::mode_err_supply:
                begin
                    emu_en       <= 1'b0;
                    usb_en       <= 1'b0;
                    temp_en      <= 1'b0;
                    blink_en     <= 1'b1;
                    ctl_pwrok    <= 1'b0;
                    ctl_standby  <= 1'b0;
                    ctl_delaying <= 1'b0;
                end

                // mode_select keeps the previous levels
                default:
                begin
                end
            endcase
        end
    end

endmodule

//--- source/led_blinker.sv
`timescale 1ns/1ps
`include "bubble_params.svh"

module led_blinker
(
    input  logic MCLK,
    input  logic MRST,
    input  logic blink_en,
    output logic blink
);

    localparam int CNT_W = $clog2(`BLINK_HALF_PERIOD + 1);

    logic [CNT_W-1:0] half_cnt;

    // blink high means the LED is dark
    always_ff @(posedge MCLK)
    begin
        if (MRST || !blink_en)
        begin
            half_cnt <= '0;
            blink    <= 1'b1;
        end
        else if (half_cnt == CNT_W'(`BLINK_HALF_PERIOD - 1))
        begin
            half_cnt <= '0;
            blink    <= ~blink;
        end
        else
        begin
            half_cnt <= half_cnt + 1'b1;
        end
    end

endmodule

//--- source/bubble_pkg.sv
package bubble_pkg;

    ////////////////////////////////////////////////////////////////////
    // data widths

    // TC77 temperature, 0.0625 degC per step
    typedef logic signed [12:0] temp_t;

    // warm-up delay selector from the dip switch
    typedef logic [1:0] delay_sel_t;

    ////////////////////////////////////////////////////////////////////
    // board run modes

    typedef enum logic [2:0]
    {
        mode_reset,
        mode_select,
        mode_emulator,
        mode_usb_standby,
        mode_err_board,
        mode_err_supply
    } run_mode_t;

endpackage

//--- source/bubble_params.svh
`ifndef BUBBLE_PARAMS_SVH
`define BUBBLE_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// LED blinker

// cycles between blink toggles
`define BLINK_HALF_PERIOD 16

//////////////////////////////////////////////////////////////////////
// TC77 sensor and temperature control

// MCLK cycles per sensor clock half-period
`define TEMP_SCK_DIV 2
// cycles between two sensor reads
`define TEMP_POLL_CYCLES 200
// below this the module is cold, 20 degC
`define TEMP_LOW_LIMIT 320

// warm-up delay table in cycles, indexed by delay_sel
`define WARMUP_DELAY_0 300
`define WARMUP_DELAY_1 600
`define WARMUP_DELAY_2 900
`define WARMUP_DELAY_3 1200

`endif
